//--- cart_config.svh
`ifndef CART_CONFIG_SVH
`define CART_CONFIG_SVH

// ====================
// Address widths
// ====================
`define CART_ADDR_W   22  // Cartridge address and masks
`define IOCTL_ADDR_W  25  // Host byte address

// ====================
// Download format
// ====================
`define HEADER_BYTES  512     // Optional copier header
`define CODE_INDEX    8'hFF   // Cheat file download
`define GG_INDEX      2       // Low index bits of a Game Gear image

// ====================
// Simulated store
// ====================
`define STORE_ADDR_W  12
`define STORE_ACK_LAT 2   // Request toggle to acknowledge toggle

`endif

//--- cart_pkg.sv
`include "cart_config.svh"

package cart_pkg;

	// Cartridge byte address, also the width of both masks
	typedef logic [`CART_ADDR_W-1:0] cart_addr_t;

	// ====================
	// Download stream
	// ====================

	// Host write after the input register
	typedef struct packed {
		logic                     valid;    // One cycle per host write
		logic                     is_code;  // Byte of a cheat file
		logic [`IOCTL_ADDR_W-1:0] addr;
		logic [7:0]               data;
	} dl_byte_t;

	// Cartridge download framing, cheat files excluded
	typedef struct packed {
		logic start;   // First cycle of the download
		logic stop;    // First cycle after it
		logic active;
	} dl_edge_t;

	// ====================
	// Store write port
	// ====================

	// Fields stay put between writes, a request is a flip of req
	typedef struct packed {
		cart_addr_t addr;
		logic [7:0] data;
		logic       req;
	} store_wr_t;

	// ====================
	// Cheat codes
	// ====================

	// Each field little-endian by byte offset within the file
	typedef struct packed {
		logic [31:0] flags;    // Offsets 0..3
		logic [31:0] addr;     // Offsets 4..7
		logic [31:0] compare;  // Offsets 8..11
		logic [31:0] replace;  // Offsets 12..15
	} cheat_code_t;

endpackage

//--- download_decode.sv
`include "cart_config.svh"

module download_decode (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  logic                     ioctl_download,
	input  logic [7:0]               ioctl_index,
	input  logic                     ioctl_wr,
	input  logic [`IOCTL_ADDR_W-1:0] ioctl_addr,
	input  logic [7:0]               ioctl_dout,
	output cart_pkg::dl_byte_t       dl_byte,
	output cart_pkg::dl_edge_t       dl_edge,
	output logic                     is_gg
);

	logic                     code_index;
	logic                     cart_dl;
	logic                     cart_dl_q;  // Previous cartridge download level
	logic                     byte_vld;
	logic                     byte_code;
	logic [`IOCTL_ADDR_W-1:0] byte_addr;
	logic [7:0]               byte_data;

	assign code_index = ioctl_index == `CODE_INDEX;
	assign cart_dl    = ioctl_download & ~code_index;

	// Strobe, framing and Game Gear flag
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			byte_vld  <= 1'b0;
			cart_dl_q <= 1'b0;
			dl_edge   <= '0;
			is_gg     <= 1'b0;
		end else begin
			byte_vld       <= ioctl_wr & ioctl_download;
			cart_dl_q      <= cart_dl;
			dl_edge.start  <= cart_dl & ~cart_dl_q;
			dl_edge.stop   <= ~cart_dl & cart_dl_q;
			dl_edge.active <= cart_dl;
			if (ioctl_wr & cart_dl)
				is_gg <= ioctl_index[4:0] == 5'(`GG_INDEX);
		end
	end

	// Byte payload
	always_ff @(posedge clk_sys) begin
		byte_code <= code_index;
		byte_addr <= ioctl_addr;
		byte_data <= ioctl_dout;
	end

	assign dl_byte = '{valid: byte_vld, is_code: byte_code, addr: byte_addr, data: byte_data};

endmodule

//--- cart_writer.sv
module cart_writer (
	input  logic                clk_sys,
	input  logic                reset,
	input  cart_pkg::dl_byte_t  dl_byte,
	input  cart_pkg::dl_edge_t  dl_edge,
	input  logic                wr_ack,
	output cart_pkg::store_wr_t store_wr,
	output logic                ioctl_wait
);

	import cart_pkg::*;

	cart_addr_t addr_cnt;   // Next store address
	cart_addr_t wr_addr;
	logic [7:0] wr_data;
	logic       wr_req;     // Request toggle
	logic       cart_byte;

	assign cart_byte = dl_byte.valid & ~dl_byte.is_code & dl_edge.active;

	// ====================
	// Toggle exchange
	// ====================

	// Flip the request and hold the host until the store answers
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			wr_req     <= 1'b0;
			ioctl_wait <= 1'b0;
			addr_cnt   <= '0;
		end else begin
			if (cart_byte) begin
				wr_req     <= ~wr_req;
				ioctl_wait <= 1'b1;
			end else if (ioctl_wait && (wr_req == wr_ack)) begin
				ioctl_wait <= 1'b0;   // Store has taken the byte
				addr_cnt   <= addr_cnt + 1'b1;
			end
			if (dl_edge.start)
				addr_cnt <= '0;   // New image starts at 0
		end
	end

	// ====================
	// Write payload
	// ====================

	// A first byte may come with the start pulse
	always_ff @(posedge clk_sys) begin
		if (cart_byte) begin
			wr_addr <= dl_edge.start ? '0 : addr_cnt;
			wr_data <= dl_byte.data;
		end
	end

	assign store_wr = '{addr: wr_addr, data: wr_data, req: wr_req};

endmodule

//--- cart_geometry.sv
`include "cart_config.svh"

module cart_geometry (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  cart_pkg::dl_byte_t   dl_byte,
	input  cart_pkg::dl_edge_t   dl_edge,
	input  cart_pkg::cart_addr_t rom_addr,
	output cart_pkg::cart_addr_t mapped_addr
);

	import cart_pkg::*;

	localparam cart_addr_t HDR_OFS = cart_addr_t'(`HEADER_BYTES);
	localparam logic [`IOCTL_ADDR_W-1:0] HDR_START = `HEADER_BYTES;
	localparam int HDR_BIT = $clog2(`HEADER_BYTES);   // Bit 9 for 512

	logic       cart_byte;
	cart_addr_t byte_addr;
	cart_addr_t cart_mask;
	cart_addr_t hdr_mask;   // Mask of the image without its header
	logic       last_hdr_bit;
	logic       hdr_flag;

	assign cart_byte = dl_byte.valid & ~dl_byte.is_code & dl_edge.active;
	assign byte_addr = dl_byte.addr[`CART_ADDR_W-1:0];

	// ====================
	// Mask tracking
	// ====================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cart_mask    <= '0;
			hdr_mask     <= '0;
			last_hdr_bit <= 1'b0;
			hdr_flag     <= 1'b0;
		end else begin
			if (cart_byte) begin
				if (dl_byte.addr == '0)
					cart_mask <= '0;
				else
					cart_mask <= cart_mask | byte_addr;

				if (dl_byte.addr == HDR_START)
					hdr_mask <= '0;
				else if (dl_byte.addr > HDR_START)
					hdr_mask <= hdr_mask | (byte_addr - HDR_OFS);

				last_hdr_bit <= dl_byte.addr[HDR_BIT];
			end
			// Odd number of half-KB blocks means a copier header
			if (dl_edge.stop)
				hdr_flag <= last_hdr_bit;
		end
	end

	// Read mapping, one address per cycle
	always_ff @(posedge clk_sys) begin
		if (hdr_flag)
			mapped_addr <= (rom_addr + HDR_OFS) & hdr_mask;   // Skip the header
		else
			mapped_addr <= rom_addr & cart_mask;
	end

endmodule

//--- cheat_assembler.sv
module cheat_assembler (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  cart_pkg::dl_byte_t    dl_byte,
	output cart_pkg::cheat_code_t cheat_code,
	output logic                  cheat_valid,
	output logic                  cheat_clear
);

	logic       code_byte;
	logic [3:0] ofs;   // Byte offset within the code

	assign code_byte = dl_byte.valid & dl_byte.is_code;
	assign ofs       = dl_byte.addr[3:0];

	// ====================
	// Field assembly
	// ====================

	// ofs[3:2] picks the field, ofs[1:0] the byte in it
	always_ff @(posedge clk_sys) begin
		if (code_byte) begin
			case (ofs[3:2])
				2'd0: cheat_code.flags[8*ofs[1:0] +: 8]   <= dl_byte.data;
				2'd1: cheat_code.addr[8*ofs[1:0] +: 8]    <= dl_byte.data;
				2'd2: cheat_code.compare[8*ofs[1:0] +: 8] <= dl_byte.data;
				default: cheat_code.replace[8*ofs[1:0] +: 8] <= dl_byte.data;
			endcase
		end
	end

	// ====================
	// Pulses
	// ====================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cheat_valid <= 1'b0;
			cheat_clear <= 1'b0;
		end else begin
			cheat_valid <= code_byte && (ofs == 4'hF);   // Last byte completes the code
			cheat_clear <= dl_byte.valid && (dl_byte.addr == '0);   // Any download
		end
	end

endmodule

//--- cart_store.sv
`include "cart_config.svh"

module cart_store (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  cart_pkg::store_wr_t  store_wr,
	input  cart_pkg::cart_addr_t rd_addr,
	output logic                 wr_ack,
	output logic [7:0]           rd_data
);

	logic [7:0]                mem [0:2**`STORE_ADDR_W-1];
	logic [`STORE_ACK_LAT-1:0] ack_sr;   // Delayed copies of the request toggle
	logic                      wr_new;

	// Request differs from its one-cycle copy right after a flip
	assign wr_new = store_wr.req != ack_sr[0];
	assign wr_ack = ack_sr[`STORE_ACK_LAT-1];

	// ====================
	// Acknowledge delay
	// ====================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ack_sr <= '0;
		end else begin
			ack_sr[0] <= store_wr.req;
			for (int i = 1; i < `STORE_ACK_LAT; i++)
				ack_sr[i] <= ack_sr[i-1];
		end
	end

	// ====================
	// Byte RAM
	// ====================
	always_ff @(posedge clk_sys) begin
		if (wr_new)
			mem[store_wr.addr[`STORE_ADDR_W-1:0]] <= store_wr.data;
		rd_data <= mem[rd_addr[`STORE_ADDR_W-1:0]];   // Low bits only
	end

endmodule

//--- cart_loader_top.sv
`include "cart_config.svh"

module cart_loader_top (
	input  logic                     clk_sys,
	input  logic                     reset,

	// Host download port
	input  logic                     ioctl_download,
	input  logic [7:0]               ioctl_index,
	input  logic                     ioctl_wr,
	input  logic [`IOCTL_ADDR_W-1:0] ioctl_addr,
	input  logic [7:0]               ioctl_dout,
	output logic                     ioctl_wait,

	// Console ROM reads, two cycles to data
	input  cart_pkg::cart_addr_t     rom_addr,
	output logic [7:0]               rom_data,

	output logic                     is_gg,
	output cart_pkg::cheat_code_t    cheat_code,
	output logic                     cheat_valid,
	output logic                     cheat_clear
);

	import cart_pkg::*;

	dl_byte_t   dl_byte;
	dl_edge_t   dl_edge;
	store_wr_t  store_wr;
	logic       wr_ack;
	cart_addr_t mapped_addr;

	download_decode u_decode (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.dl_byte        (dl_byte),
		.dl_edge        (dl_edge),
		.is_gg          (is_gg)
	);

	cart_writer u_writer (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.dl_byte    (dl_byte),
		.dl_edge    (dl_edge),
		.wr_ack     (wr_ack),
		.store_wr   (store_wr),
		.ioctl_wait (ioctl_wait)
	);

	cart_geometry u_geometry (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.dl_byte     (dl_byte),
		.dl_edge     (dl_edge),
		.rom_addr    (rom_addr),
		.mapped_addr (mapped_addr)
	);

	cart_store u_store (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.store_wr (store_wr),
		.rd_addr  (mapped_addr),
		.wr_ack   (wr_ack),
		.rd_data  (rom_data)
	);

	cheat_assembler u_cheat (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.dl_byte     (dl_byte),
		.cheat_code  (cheat_code),
		.cheat_valid (cheat_valid),
		.cheat_clear (cheat_clear)
	);

endmodule

//--- cart_loader_asserts.sv
module cart_loader_asserts (
	input logic clk_sys,
	input logic reset,
	input logic wr_strobe,   // Cartridge byte into the writer
	input logic ioctl_wait,
	input logic wr_req,
	input logic wr_ack,
	input logic cheat_valid
);

	int fail_count = 0;

	wait_rise: assert property (@(posedge clk_sys) disable iff (reset)
		$rose(ioctl_wait) |-> $past(wr_strobe))
	else begin
		fail_count++;
		$error("ioctl_wait rose without a cartridge write strobe");
	end

	// Release only once the store has echoed the toggle
	wait_fall: assert property (@(posedge clk_sys) disable iff (reset)
		$fell(ioctl_wait) |-> $past(wr_req == wr_ack))
	else begin
		fail_count++;
		$error("ioctl_wait fell while the toggles differed");
	end

	valid_pulse: assert property (@(posedge clk_sys) disable iff (reset)
		cheat_valid |=> !cheat_valid)
	else begin
		fail_count++;
		$error("cheat_valid stayed high for two cycles");
	end

endmodule

bind cart_writer cart_loader_asserts wr_chk (
	.clk_sys     (clk_sys),
	.reset       (reset),
	.wr_strobe   (cart_byte),
	.ioctl_wait  (ioctl_wait),
	.wr_req      (wr_req),
	.wr_ack      (wr_ack),
	.cheat_valid (1'b0)
);

// Exchange inputs tied off, only the valid pulse is watched here
bind cheat_assembler cart_loader_asserts valid_chk (
	.clk_sys     (clk_sys),
	.reset       (reset),
	.wr_strobe   (1'b0),
	.ioctl_wait  (1'b0),
	.wr_req      (1'b0),
	.wr_ack      (1'b0),
	.cheat_valid (cheat_valid)
);

//--- tb_cart_loader.sv
`include "cart_config.svh"

module tb_cart_loader;

	import cart_pkg::*;

	localparam int NREADS = 200;   // Per cartridge

	logic                     clk_sys = 1'b0;
	logic                     reset;
	logic                     ioctl_download;
	logic [7:0]               ioctl_index;
	logic                     ioctl_wr;
	logic [`IOCTL_ADDR_W-1:0] ioctl_addr;
	logic [7:0]               ioctl_dout;
	logic                     ioctl_wait;
	cart_addr_t               rom_addr;
	logic [7:0]               rom_data;
	logic                     is_gg;
	cheat_code_t              cheat_code;
	logic                     cheat_valid;
	logic                     cheat_clear;

	logic [31:0] rng = 32'hac4a_7745;
	logic [7:0]  model_mem [0:2**`STORE_ADDR_W-1];
	bit          written [0:2**`STORE_ADDR_W-1];   // Store location holds a known byte
	cart_addr_t  m_cart_mask = '0;
	cart_addr_t  m_hdr_mask = '0;
	logic        m_hdr_flag = 1'b0;
	int          cycles = 0;
	int          cycle_limit = 1000000;
	int          valid_seen = 0;
	int          clear_seen = 0;

	cart_loader_top dut0 (.*);

	always #5 clk_sys = ~clk_sys;

	// ====================
	// Checks
	// ====================
	task automatic abort_run();
		$display("TESTBENCH FAILED");
		$fatal(1);
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("Fail %s: expected %b, got %b", name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp) begin
			$display("Fail %s: expected %02h, got %02h", name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_addr(input string name, input cart_addr_t exp, input cart_addr_t act);
		if (act !== exp) begin
			$display("Fail %s: expected %06h, got %06h", name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_code(input string name, input cheat_code_t exp, input cheat_code_t act);
		if (act !== exp) begin
			$display("Fail %s: expected %032h, got %032h", name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (act != exp) begin
			$display("Fail %s: expected %0d, got %0d", name, exp, act);
			abort_run();
		end
	endtask

	function automatic logic [31:0] next_rand();
		rng = rng * 32'd1664525 + 32'd1013904223;
		return rng;
	endfunction

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles > cycle_limit) begin
			$display("Timeout after %0d cycles, the DUT stopped answering", cycles);
			abort_run();
		end
	end

	// Pulse counts, sampled away from the active edge
	always @(negedge clk_sys) begin
		if (cheat_valid)
			valid_seen++;
		if (cheat_clear)
			clear_seen++;
	end

	// ====================
	// Host side
	// ====================

	// One strobe, returns two edges after it was sampled
	task automatic host_write(input int addr, input logic [7:0] data);
		@(posedge clk_sys);
		#1;
		ioctl_wr   = 1'b1;
		ioctl_addr = `IOCTL_ADDR_W'(addr);
		ioctl_dout = data;
		@(posedge clk_sys);
		#1;
		ioctl_wr = 1'b0;
		@(posedge clk_sys);
		#1;
		check_bit("cheat_clear", addr == 0, cheat_clear);
	endtask

	task automatic load_cart(input logic [7:0] idx, input int len);
		logic [7:0] data;
		@(posedge clk_sys);
		#1;
		ioctl_download = 1'b1;
		ioctl_index    = idx;
		for (int i = 0; i < len; i++) begin
			data = 8'(next_rand());
			host_write(i, data);
			check_bit("ioctl_wait rise", 1'b1, ioctl_wait);
			while (ioctl_wait) begin
				@(posedge clk_sys);
				#1;
			end
			model_mem[i] = data;
			written[i]   = 1'b1;
			if (i == 0)
				m_cart_mask = '0;
			else
				m_cart_mask |= cart_addr_t'(i);
			if (i == `HEADER_BYTES)
				m_hdr_mask = '0;
			else if (i > `HEADER_BYTES)
				m_hdr_mask |= cart_addr_t'(i - `HEADER_BYTES);
		end
		@(posedge clk_sys);
		#1;
		ioctl_download = 1'b0;
		repeat (3) @(posedge clk_sys);   // Stop pulse into the header flag
		#1;
		m_hdr_flag = ((len - 1) & `HEADER_BYTES) != 0;
		check_bit("is_gg", idx[4:0] == 5'(`GG_INDEX), is_gg);
		check_bit("hdr_flag", m_hdr_flag, dut0.u_geometry.hdr_flag);
		check_addr("cart_mask", m_cart_mask, dut0.u_geometry.cart_mask);
		check_addr("hdr_mask", m_hdr_mask, dut0.u_geometry.hdr_mask);
	endtask

	// Three codes in one file, 16 bytes each in shuffled order
	task automatic load_codes(input int count);
		logic [7:0]  b [0:15];
		int          ord [0:15];
		int          j;
		int          t;
		cheat_code_t exp;
		@(posedge clk_sys);
		#1;
		ioctl_download = 1'b1;
		ioctl_index    = `CODE_INDEX;
		for (int k = 0; k < count; k++) begin
			for (int i = 0; i < 16; i++) begin
				b[i]   = 8'(next_rand());
				ord[i] = i;
			end
			for (int i = 14; i > 0; i--) begin   // Offset 15 stays last
				j      = int'(next_rand() % (i + 1));
				t      = ord[i];
				ord[i] = ord[j];
				ord[j] = t;
			end
			exp.flags   = {b[3], b[2], b[1], b[0]};
			exp.addr    = {b[7], b[6], b[5], b[4]};
			exp.compare = {b[11], b[10], b[9], b[8]};
			exp.replace = {b[15], b[14], b[13], b[12]};
			for (int i = 0; i < 16; i++) begin
				host_write(16 * k + ord[i], b[ord[i]]);
				check_bit("cheat_valid", ord[i] == 15, cheat_valid);
				check_bit("ioctl_wait idle", 1'b0, ioctl_wait);
			end
			check_code("cheat_code", exp, cheat_code);
		end
		@(posedge clk_sys);
		#1;
		ioctl_download = 1'b0;
		repeat (2) @(posedge clk_sys);
		#1;
	endtask

	// Back-to-back reads, address checked after one cycle and data after two
	task automatic read_back(input string name);
		cart_addr_t exp_map [0:NREADS-1];
		logic [7:0] exp_data [0:NREADS-1];
		bit         exp_ok [0:NREADS-1];
		cart_addr_t a;
		int         checked;
		checked = 0;
		for (int i = 0; i < NREADS + 2; i++) begin
			@(posedge clk_sys);
			#1;
			if (i >= 1 && i <= NREADS)
				check_addr({name, " address"}, exp_map[i-1], dut0.mapped_addr);
			if (i >= 2 && exp_ok[i-2]) begin
				check_byte({name, " data"}, exp_data[i-2], rom_data);
				checked++;
			end
			if (i < NREADS) begin
				a        = cart_addr_t'(next_rand());
				rom_addr = a;
				if (m_hdr_flag)
					exp_map[i] = (a + cart_addr_t'(`HEADER_BYTES)) & m_hdr_mask;
				else
					exp_map[i] = a & m_cart_mask;
				exp_ok[i]   = written[exp_map[i][`STORE_ADDR_W-1:0]];
				exp_data[i] = model_mem[exp_map[i][`STORE_ADDR_W-1:0]];
			end
		end
		if (checked == 0) begin
			$display("No read of the %s test landed on a loaded byte", name);
			abort_run();
		end
	endtask

	// ====================
	// Test sequence
	// ====================
	initial begin
		int          len_plain;
		int          len_hdr;
		logic [31:0] r;
		logic [7:0]  idx_plain;
		logic [7:0]  idx_hdr;
		reset          = 1'b1;
		ioctl_download = 1'b0;
		ioctl_index    = 8'h00;
		ioctl_wr       = 1'b0;
		ioctl_addr     = '0;
		ioctl_dout     = 8'h00;
		rom_addr       = '0;

		do
			len_plain = 600 + int'(next_rand() % 2401);
		while (len_plain % 1024 == 0 || ((len_plain - 1) & `HEADER_BYTES) != 0);
		do
			len_hdr = 600 + int'(next_rand() % 2401);
		while (len_hdr % 1024 == 0 || ((len_hdr - 1) & `HEADER_BYTES) == 0);
		r         = next_rand();
		idx_plain = {r[7:5], 4'b0000, r[0]};   // Low bits 0 or 1
		idx_hdr   = {r[15:13], 5'(`GG_INDEX)};
		cycle_limit = 40 * (len_plain + len_hdr + 48) + 2 * (NREADS + 2) + 500;

		repeat (2) @(posedge clk_sys);
		#1;
		reset = 1'b0;

		load_cart(idx_plain, len_plain);
		read_back("plain");
		load_cart(idx_hdr, len_hdr);
		read_back("headered");
		load_codes(3);

		// Cheat files leave the flag of the last cartridge alone
		check_bit("is_gg after codes", idx_hdr[4:0] == 5'(`GG_INDEX), is_gg);
		check_count("cheat_valid pulses", 3, valid_seen);
		check_count("cheat_clear pulses", 3, clear_seen);

		if (dut0.u_writer.wr_chk.fail_count + dut0.u_cheat.valid_chk.fail_count == 0) begin
			$display("TESTBENCH PASSED");
			$finish;
		end else begin
			$display("Assertion failures were reported");
			abort_run();
		end
	end

endmodule

//--- vlog.f
+incdir+.
cart_pkg.sv
download_decode.sv
cart_writer.sv
cart_geometry.sv
cheat_assembler.sv
cart_store.sv
cart_loader_top.sv
cart_loader_asserts.sv
tb_cart_loader.sv

//--- Makefile
TOP = tb_cart_loader

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module $(TOP)

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTBENCH PASSED"

clean:
	rm -rf obj_dir
